// ==== npu_buf_sys.f ====
verilog/npu_buf_pkg.sv
verilog/apb_cfg_regs.sv
verilog/dma_beat_router.sv
verilog/buf_bank.sv
verilog/npu_buf_sys.sv
dv/tb_npu_buf_sys.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_npu_buf_sys -f npu_buf_sys.f
	@out="$$(./obj_dir/Vtb_npu_buf_sys)"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== dv/tb_npu_buf_sys.sv ====
// NPU buffer system testbench
`timescale 1ns/1ps

module tb_npu_buf_sys;
  import npu_buf_pkg::*;

  localparam int CYCLE_LIMIT = 4000;  // Stimulus needs about 350 cycles
  localparam int NWORDS      = 8;     // Words per bank in the DMA tests

  logic                  xclk;
  logic                  i_arst_n;
  logic                  i_psel;
  logic                  i_penable;
  logic                  i_pwrite;
  logic [APB_AW-1:0]     i_paddr;
  logic [31:0]           i_pwdata;
  logic [31:0]           o_prdata;
  logic                  i_dma_write;
  logic                  i_dma_read;
  logic [DMA_AW-1:0]     i_dma_addr;
  logic [BEAT_W-1:0]     i_dma_wdata;
  logic [BEAT_BYTES-1:0] i_dma_wstrb;
  logic [BEAT_W-1:0]     o_dma_rdata;
  logic                  o_dma_rvalid;
  logic                  i_core_iob_cs;
  logic                  i_core_iob_we;
  logic [IOB_W/8-1:0]    i_core_iob_be;
  logic [IOB_AW-1:0]     i_core_iob_addr;
  iob_word_t             i_core_iob_wdata;
  iob_word_t             o_core_iob_rdata;
  logic                  i_core_wb_cs;
  logic                  i_core_wb_we;
  logic [WB_W/8-1:0]     i_core_wb_be;
  logic [WB_AW-1:0]      i_core_wb_addr;
  wb_word_t              i_core_wb_wdata;
  wb_word_t              o_core_wb_rdata;
  logic                  i_core_instb_cs;
  logic                  i_core_instb_we;
  logic [INSTB_W/8-1:0]  i_core_instb_be;
  logic [INSTB_AW-1:0]   i_core_instb_addr;
  instb_word_t           i_core_instb_wdata;
  instb_word_t           o_core_instb_rdata;
  logic                  o_npu_start;
  logic                  o_npu_stop;
  logic                  i_npu_done;
  logic                  o_interrupt;

  // Reference buffers indexed by beat address * 16 + byte
  logic [7:0]   ref_mem [3][8192];
  logic [31:0]  seed;
  logic         own;  // Ownership as last written
  int           cycles = 0;

  // Expectations set at drive time and moved to exp_* at the clock edge
  logic         nxt_rvalid;
  logic [127:0] nxt_rdata;
  logic         nxt_start;
  logic         nxt_stop;
  logic         nxt_irq_clr;
  logic [2:0]   nxt_core_rd;
  logic [511:0] nxt_core_word;
  logic         exp_rvalid;
  logic [127:0] exp_rdata;
  logic         exp_start;
  logic         exp_stop;
  logic         exp_irq;
  logic [2:0]   core_chk;
  iob_word_t    exp_core_iob;
  wb_word_t     exp_core_wb;
  instb_word_t  exp_core_instb;

  npu_buf_sys u_npu_buf_sys (.*);

  always #10 xclk = ~xclk;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int beats_in_word(input logic [1:0] bank);
    case (bank)
      BANK_IOB: return IOB_BEATS;
      BANK_WB:  return WB_BEATS;
      default:  return INSTB_BEATS;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [511:0] got,
                                 input logic [511:0] exp);
    $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("TEST FAIL");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic drop_strobes();
    i_dma_write     = 1'b0;
    i_dma_read      = 1'b0;
    i_core_iob_cs   = 1'b0;
    i_core_wb_cs    = 1'b0;
    i_core_instb_cs = 1'b0;
    nxt_rvalid      = 1'b0;
    nxt_core_rd     = 3'b000;
  endtask

  task automatic bus_idle();
    @(negedge xclk);
    drop_strobes();
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(negedge xclk);
    i_psel    = 1'b1;
    i_pwrite  = 1'b1;
    i_penable = 1'b0;
    i_paddr   = addr;
    i_pwdata  = data;
    @(negedge xclk);
    i_penable   = 1'b1;  // Access phase
    nxt_start   = (addr == REG_CTRL) && data[0];
    nxt_stop    = (addr == REG_CTRL) && data[1];
    nxt_irq_clr = (addr == REG_IRQ) && data[0];
    @(negedge xclk);
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    nxt_start   = 1'b0;
    nxt_stop    = 1'b0;
    nxt_irq_clr = 1'b0;
  endtask

  task automatic apb_check(input logic [APB_AW-1:0] addr, input logic [31:0] exp);
    @(negedge xclk);
    i_psel    = 1'b1;
    i_pwrite  = 1'b0;
    i_penable = 1'b0;
    i_paddr   = addr;
    @(negedge xclk);
    i_penable = 1'b1;
    #5;
    a_prdata: assert (o_prdata == exp)
      else report_mismatch("o_prdata", 512'(o_prdata), 512'(exp));
    @(negedge xclk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic set_own(input logic value);
    bus_idle();
    apb_write(REG_CTRL, {29'h0, value, 2'b00});
    own = value;
  endtask

  task automatic pulse_done();
    @(negedge xclk);
    i_npu_done = 1'b1;
    @(negedge xclk);
    i_npu_done = 1'b0;
  endtask

  task automatic dma_write(input logic [1:0] bank, input int beat,
                           input logic [BEAT_W-1:0] data, input logic [15:0] strb);
    @(negedge xclk);
    drop_strobes();
    i_dma_write = 1'b1;
    i_dma_addr  = {bank, 14'(beat)};
    i_dma_wdata = data;
    i_dma_wstrb = strb;
    if (own) begin  // A core-owned bank keeps its contents
      for (int b = 0; b < BEAT_BYTES; b++)
        if (strb[b])
          ref_mem[bank][13'(beat * BEAT_BYTES + b)] = data[b*8 +: 8];
    end
  endtask

  task automatic dma_read(input logic [1:0] bank, input int beat);
    @(negedge xclk);
    drop_strobes();
    i_dma_read = 1'b1;
    i_dma_addr = {bank, 14'(beat)};
    nxt_rvalid = (bank != 2'd3);  // Code 3 returns nothing
    if (nxt_rvalid) begin
      for (int b = 0; b < BEAT_BYTES; b++)
        nxt_rdata[b*8 +: 8] = ref_mem[bank][13'(beat * BEAT_BYTES + b)];
    end
  endtask

  task automatic core_access(input logic [1:0] bank, input logic we, input int word,
                             input logic [511:0] data, input logic [63:0] be);
    int nb;
    nb = beats_in_word(bank) * BEAT_BYTES;
    @(negedge xclk);
    drop_strobes();
    case (bank)
      BANK_IOB: begin
        i_core_iob_cs    = 1'b1;
        i_core_iob_we    = we;
        i_core_iob_addr  = IOB_AW'(word);
        i_core_iob_wdata = data[IOB_W-1:0];
        i_core_iob_be    = be[IOB_W/8-1:0];
      end
      BANK_WB: begin
        i_core_wb_cs    = 1'b1;
        i_core_wb_we    = we;
        i_core_wb_addr  = WB_AW'(word);
        i_core_wb_wdata = data;
        i_core_wb_be    = be;
      end
      default: begin
        i_core_instb_cs    = 1'b1;
        i_core_instb_we    = we;
        i_core_instb_addr  = INSTB_AW'(word);
        i_core_instb_wdata = data[INSTB_W-1:0];
        i_core_instb_be    = be[INSTB_W/8-1:0];
      end
    endcase
    // Word is the DMA lanes in lane order
    nxt_core_word = '0;
    for (int j = 0; j < nb; j++) begin
      if (we && be[j])
        ref_mem[bank][13'(word * nb + j)] = data[j*8 +: 8];
      nxt_core_word[j*8 +: 8] = ref_mem[bank][13'(word * nb + j)];
    end
    if (!we)
      nxt_core_rd = 3'b001 << bank;
  endtask

  always @(posedge xclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      exp_rvalid <= 1'b0;
      exp_start  <= 1'b0;
      exp_stop   <= 1'b0;
      exp_irq    <= 1'b0;
      core_chk   <= 3'b000;
    end else begin
      exp_rvalid <= nxt_rvalid;
      if (nxt_rvalid)
        exp_rdata <= nxt_rdata;
      exp_start <= nxt_start;
      exp_stop  <= nxt_stop;
      if (i_npu_done)
        exp_irq <= 1'b1;
      else if (nxt_irq_clr)
        exp_irq <= 1'b0;
      if (nxt_core_rd[0])
        exp_core_iob <= nxt_core_word[IOB_W-1:0];
      if (nxt_core_rd[1])
        exp_core_wb <= nxt_core_word;
      if (nxt_core_rd[2])
        exp_core_instb <= nxt_core_word[INSTB_W-1:0];
      core_chk <= core_chk | nxt_core_rd;
    end
  end

  // Outputs are sampled on the falling edge half a cycle after they change
  a_rvalid: assert property (@(negedge xclk) disable iff (!i_arst_n)
    o_dma_rvalid == exp_rvalid)
    else report_mismatch("o_dma_rvalid", 512'(o_dma_rvalid), 512'(exp_rvalid));
  a_rdata: assert property (@(negedge xclk) disable iff (!i_arst_n)
    exp_rvalid |-> o_dma_rdata == exp_rdata)
    else report_mismatch("o_dma_rdata", 512'(o_dma_rdata), 512'(exp_rdata));
  a_start: assert property (@(negedge xclk) disable iff (!i_arst_n)
    o_npu_start == exp_start)
    else report_mismatch("o_npu_start", 512'(o_npu_start), 512'(exp_start));
  a_stop: assert property (@(negedge xclk) disable iff (!i_arst_n)
    o_npu_stop == exp_stop)
    else report_mismatch("o_npu_stop", 512'(o_npu_stop), 512'(exp_stop));
  a_irq: assert property (@(negedge xclk) disable iff (!i_arst_n)
    o_interrupt == exp_irq)
    else report_mismatch("o_interrupt", 512'(o_interrupt), 512'(exp_irq));
  a_core_iob: assert property (@(negedge xclk) disable iff (!i_arst_n)
    core_chk[0] |-> o_core_iob_rdata == exp_core_iob)
    else report_mismatch("o_core_iob_rdata", 512'(o_core_iob_rdata), 512'(exp_core_iob));
  a_core_wb: assert property (@(negedge xclk) disable iff (!i_arst_n)
    core_chk[1] |-> o_core_wb_rdata == exp_core_wb)
    else report_mismatch("o_core_wb_rdata", o_core_wb_rdata, exp_core_wb);
  a_core_instb: assert property (@(negedge xclk) disable iff (!i_arst_n)
    core_chk[2] |-> o_core_instb_rdata == exp_core_instb)
    else report_mismatch("o_core_instb_rdata", 512'(o_core_instb_rdata),
                         512'(exp_core_instb));

  always @(posedge xclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [BEAT_W-1:0] beat;
    logic [511:0]      wide;
    logic [63:0]       be;
    logic [15:0]       strb;
    xclk               = 1'b0;
    i_arst_n           = 1'b0;
    i_psel             = 1'b0;
    i_penable          = 1'b0;
    i_pwrite           = 1'b0;
    i_paddr            = '0;
    i_pwdata           = '0;
    i_dma_addr         = '0;
    i_dma_wdata        = '0;
    i_dma_wstrb        = '0;
    i_core_iob_we      = 1'b0;
    i_core_iob_be      = '0;
    i_core_iob_addr    = '0;
    i_core_iob_wdata   = '0;
    i_core_wb_we       = 1'b0;
    i_core_wb_be       = '0;
    i_core_wb_addr     = '0;
    i_core_wb_wdata    = '0;
    i_core_instb_we    = 1'b0;
    i_core_instb_be    = '0;
    i_core_instb_addr  = '0;
    i_core_instb_wdata = '0;
    i_npu_done         = 1'b0;
    nxt_start          = 1'b0;
    nxt_stop           = 1'b0;
    nxt_irq_clr        = 1'b0;
    nxt_rdata          = '0;
    nxt_core_word      = '0;
    own                = 1'b0;
    seed               = 32'h999b5e4a;
    drop_strobes();
    repeat (10) @(posedge xclk);
    @(negedge xclk);
    i_arst_n = 1'b1;

    apb_check(REG_STATUS, 32'h0);

    // Start, done, interrupt clear, stop
    apb_write(REG_CTRL, 32'h1);
    apb_check(REG_STATUS, 32'h1);
    pulse_done();
    apb_check(REG_STATUS, 32'h0);
    apb_check(REG_IRQ, 32'h1);
    apb_write(REG_IRQ, 32'h1);
    apb_check(REG_IRQ, 32'h0);
    apb_write(REG_CTRL, 32'h1);
    apb_write(REG_CTRL, 32'h2);
    apb_check(REG_STATUS, 32'h0);

    // DMA owns the banks with a full fill then a strobed overwrite
    set_own(1'b1);
    apb_check(REG_STATUS, 32'h2);
    apb_check(REG_CTRL, 32'h4);
    for (int bk = 0; bk < 3; bk++) begin
      for (int i = 0; i < NWORDS * beats_in_word(2'(bk)); i++) begin
        beat = {next_rand(), next_rand(), next_rand(), next_rand()};
        dma_write(2'(bk), i, beat, 16'hffff);
      end
    end
    for (int bk = 0; bk < 3; bk++) begin
      for (int i = 0; i < NWORDS * beats_in_word(2'(bk)); i++) begin
        beat = {next_rand(), next_rand(), next_rand(), next_rand()};
        strb = 16'(next_rand());
        if (strb == 16'h0)
          strb = 16'h8000;
        dma_write(2'(bk), i, beat, strb);
      end
    end
    for (int bk = 0; bk < 3; bk++)
      for (int i = 0; i < NWORDS * beats_in_word(2'(bk)); i++)
        dma_read(2'(bk), i);  // Back to back

    // Writes while the core owns the banks
    set_own(1'b0);
    for (int bk = 0; bk < 3; bk++) begin
      for (int i = 0; i < 4; i++) begin
        beat = {next_rand(), next_rand(), next_rand(), next_rand()};
        dma_write(2'(bk), i, beat, 16'hffff);
      end
    end
    set_own(1'b1);
    for (int bk = 0; bk < 3; bk++)
      for (int i = 0; i < 4; i++)
        dma_read(2'(bk), i);

    // Core side reads and byte-enabled writes
    set_own(1'b0);
    for (int bk = 0; bk < 3; bk++)
      for (int w = 0; w < NWORDS; w++)
        core_access(2'(bk), 1'b0, w, '0, '0);
    for (int bk = 0; bk < 3; bk++) begin
      for (int k = 0; k < 16; k++)
        wide[k*32 +: 32] = next_rand();
      be    = {next_rand(), next_rand()};
      be[0] = 1'b1;
      core_access(2'(bk), 1'b1, 3, wide, be);
      core_access(2'(bk), 1'b0, 3, '0, '0);
    end
    set_own(1'b1);
    for (int bk = 0; bk < 3; bk++)
      for (int l = 0; l < beats_in_word(2'(bk)); l++)
        dma_read(2'(bk), 3 * beats_in_word(2'(bk)) + l);

    // Unused bank code then a normal read
    dma_read(2'd3, 5);
    dma_read(BANK_INSTB, 0);
    bus_idle();
    repeat (3) @(negedge xclk);
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== verilog/npu_buf_sys.sv ====
// NPU buffer system top
`timescale 1ns/1ps

module npu_buf_sys (
  input  logic                                 xclk,
  input  logic                                 i_arst_n,
  // APB
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [npu_buf_pkg::APB_AW-1:0]       i_paddr,
  input  logic [31:0]                          i_pwdata,
  output logic [31:0]                          o_prdata,
  // DMA beats
  input  logic                                 i_dma_write,
  input  logic                                 i_dma_read,
  input  logic [npu_buf_pkg::DMA_AW-1:0]       i_dma_addr,
  input  logic [npu_buf_pkg::BEAT_W-1:0]       i_dma_wdata,
  input  logic [npu_buf_pkg::BEAT_BYTES-1:0]   i_dma_wstrb,
  output logic [npu_buf_pkg::BEAT_W-1:0]       o_dma_rdata,
  output logic                                 o_dma_rvalid,
  // Core port, IOB
  input  logic                                 i_core_iob_cs,
  input  logic                                 i_core_iob_we,
  input  logic [npu_buf_pkg::IOB_W/8-1:0]      i_core_iob_be,
  input  logic [npu_buf_pkg::IOB_AW-1:0]       i_core_iob_addr,
  input  npu_buf_pkg::iob_word_t               i_core_iob_wdata,
  output npu_buf_pkg::iob_word_t               o_core_iob_rdata,
  // Core port, WB
  input  logic                                 i_core_wb_cs,
  input  logic                                 i_core_wb_we,
  input  logic [npu_buf_pkg::WB_W/8-1:0]       i_core_wb_be,
  input  logic [npu_buf_pkg::WB_AW-1:0]        i_core_wb_addr,
  input  npu_buf_pkg::wb_word_t                i_core_wb_wdata,
  output npu_buf_pkg::wb_word_t                o_core_wb_rdata,
  // Core port, INSTB
  input  logic                                 i_core_instb_cs,
  input  logic                                 i_core_instb_we,
  input  logic [npu_buf_pkg::INSTB_W/8-1:0]    i_core_instb_be,
  input  logic [npu_buf_pkg::INSTB_AW-1:0]     i_core_instb_addr,
  input  npu_buf_pkg::instb_word_t             i_core_instb_wdata,
  output npu_buf_pkg::instb_word_t             o_core_instb_rdata,
  // Core control
  output logic                                 o_npu_start,
  output logic                                 o_npu_stop,
  input  logic                                 i_npu_done,
  output logic                                 o_interrupt
);
  import npu_buf_pkg::*;

  logic dma_own;  // Buffer ownership, 1 gives the DMA the banks

  logic                 iob_cs;
  logic                 iob_we;
  logic [IOB_AW-1:0]    iob_addr;
  iob_word_t            iob_wdata;
  logic [IOB_W/8-1:0]   iob_be;
  iob_word_t            iob_rdata;

  logic                 wb_cs;
  logic                 wb_we;
  logic [WB_AW-1:0]     wb_addr;
  wb_word_t             wb_wdata;
  logic [WB_W/8-1:0]    wb_be;
  wb_word_t             wb_rdata;

  logic                 instb_cs;
  logic                 instb_we;
  logic [INSTB_AW-1:0]  instb_addr;
  instb_word_t          instb_wdata;
  logic [INSTB_W/8-1:0] instb_be;
  instb_word_t          instb_rdata;

  apb_cfg_regs u_apb_cfg_regs (
    .xclk        (xclk),
    .i_arst_n    (i_arst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .i_npu_done  (i_npu_done),
    .o_npu_start (o_npu_start),
    .o_npu_stop  (o_npu_stop),
    .o_dma_own   (dma_own),
    .o_interrupt (o_interrupt)
  );

  dma_beat_router u_dma_beat_router (
    .xclk          (xclk),
    .i_arst_n      (i_arst_n),
    .i_dma_write   (i_dma_write),
    .i_dma_read    (i_dma_read),
    .i_dma_addr    (i_dma_addr),
    .i_dma_wdata   (i_dma_wdata),
    .i_dma_wstrb   (i_dma_wstrb),
    .o_iob_cs      (iob_cs),
    .o_iob_we      (iob_we),
    .o_iob_addr    (iob_addr),
    .o_iob_wdata   (iob_wdata),
    .o_iob_be      (iob_be),
    .o_wb_cs       (wb_cs),
    .o_wb_we       (wb_we),
    .o_wb_addr     (wb_addr),
    .o_wb_wdata    (wb_wdata),
    .o_wb_be       (wb_be),
    .o_instb_cs    (instb_cs),
    .o_instb_we    (instb_we),
    .o_instb_addr  (instb_addr),
    .o_instb_wdata (instb_wdata),
    .o_instb_be    (instb_be),
    .i_iob_rdata   (iob_rdata),
    .i_wb_rdata    (wb_rdata),
    .i_instb_rdata (instb_rdata),
    .o_dma_rdata   (o_dma_rdata),
    .o_dma_rvalid  (o_dma_rvalid)
  );

  buf_bank #(.word_t(iob_word_t), .AW(IOB_AW)) u_iob_bank (
    .xclk         (xclk),
    .i_dma_own    (dma_own),
    .i_dma_cs     (iob_cs),
    .i_dma_we     (iob_we),
    .i_dma_addr   (iob_addr),
    .i_dma_wdata  (iob_wdata),
    .i_dma_be     (iob_be),
    .i_core_cs    (i_core_iob_cs),
    .i_core_we    (i_core_iob_we),
    .i_core_addr  (i_core_iob_addr),
    .i_core_wdata (i_core_iob_wdata),
    .i_core_be    (i_core_iob_be),
    .o_dma_rdata  (iob_rdata),
    .o_core_rdata (o_core_iob_rdata)
  );

  buf_bank #(.word_t(wb_word_t), .AW(WB_AW)) u_wb_bank (
    .xclk         (xclk),
    .i_dma_own    (dma_own),
    .i_dma_cs     (wb_cs),
    .i_dma_we     (wb_we),
    .i_dma_addr   (wb_addr),
    .i_dma_wdata  (wb_wdata),
    .i_dma_be     (wb_be),
    .i_core_cs    (i_core_wb_cs),
    .i_core_we    (i_core_wb_we),
    .i_core_addr  (i_core_wb_addr),
    .i_core_wdata (i_core_wb_wdata),
    .i_core_be    (i_core_wb_be),
    .o_dma_rdata  (wb_rdata),
    .o_core_rdata (o_core_wb_rdata)
  );

  buf_bank #(.word_t(instb_word_t), .AW(INSTB_AW)) u_instb_bank (
    .xclk         (xclk),
    .i_dma_own    (dma_own),
    .i_dma_cs     (instb_cs),
    .i_dma_we     (instb_we),
    .i_dma_addr   (instb_addr),
    .i_dma_wdata  (instb_wdata),
    .i_dma_be     (instb_be),
    .i_core_cs    (i_core_instb_cs),
    .i_core_we    (i_core_instb_we),
    .i_core_addr  (i_core_instb_addr),
    .i_core_wdata (i_core_instb_wdata),
    .i_core_be    (i_core_instb_be),
    .o_dma_rdata  (instb_rdata),
    .o_core_rdata (o_core_instb_rdata)
  );

endmodule

// ==== verilog/buf_bank.sv ====
// Shared byte-strobed buffer bank
`timescale 1ns/1ps

module buf_bank #(
  parameter type word_t = logic [127:0],
  parameter int  AW     = 8
) (
  input  logic                       xclk,
  input  logic                       i_dma_own,
  // DMA request
  input  logic                       i_dma_cs,
  input  logic                       i_dma_we,
  input  logic [AW-1:0]              i_dma_addr,
  input  word_t                      i_dma_wdata,
  input  logic [$bits(word_t)/8-1:0] i_dma_be,
  // Core request
  input  logic                       i_core_cs,
  input  logic                       i_core_we,
  input  logic [AW-1:0]              i_core_addr,
  input  word_t                      i_core_wdata,
  input  logic [$bits(word_t)/8-1:0] i_core_be,
  // Read words
  output word_t                      o_dma_rdata,
  output word_t                      o_core_rdata
);

  localparam int NB = $bits(word_t) / 8;

  word_t mem [0:(1 << AW) - 1];

  logic          cs;
  logic          we;
  logic [AW-1:0] addr;
  word_t         wdata;
  logic [NB-1:0] be;

  // Owner's request reaches the memory
  always_comb begin
    if (i_dma_own) begin
      cs    = i_dma_cs;
      we    = i_dma_we;
      addr  = i_dma_addr;
      wdata = i_dma_wdata;
      be    = i_dma_be;
    end else begin
      cs    = i_core_cs;
      we    = i_core_we;
      addr  = i_core_addr;
      wdata = i_core_wdata;
      be    = i_core_be;
    end
  end

  always_ff @(posedge xclk) begin
    if (cs && we) begin
      for (int b = 0; b < NB; b++) begin
        if (be[b])
          mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
      end
    end
  end

  // Each side keeps its last read word
  always_ff @(posedge xclk) begin
    if (cs && !we) begin
      if (i_dma_own)
        o_dma_rdata <= mem[addr];
      else
        o_core_rdata <= mem[addr];
    end
  end

  a_write_has_be: assert property (
    @(posedge xclk) (cs && we) |-> (be != '0)
  ) else $error("buffer write with no byte enables");

endmodule

// ==== verilog/dma_beat_router.sv ====
// DMA beat to buffer lane router
`timescale 1ns/1ps

module dma_beat_router (
  input  logic                                 xclk,
  input  logic                                 i_arst_n,
  input  logic                                 i_dma_write,
  input  logic                                 i_dma_read,
  input  logic [npu_buf_pkg::DMA_AW-1:0]       i_dma_addr,
  input  logic [npu_buf_pkg::BEAT_W-1:0]       i_dma_wdata,
  input  logic [npu_buf_pkg::BEAT_BYTES-1:0]   i_dma_wstrb,
  // IOB request
  output logic                                 o_iob_cs,
  output logic                                 o_iob_we,
  output logic [npu_buf_pkg::IOB_AW-1:0]       o_iob_addr,
  output npu_buf_pkg::iob_word_t               o_iob_wdata,
  output logic [npu_buf_pkg::IOB_W/8-1:0]      o_iob_be,
  // WB request
  output logic                                 o_wb_cs,
  output logic                                 o_wb_we,
  output logic [npu_buf_pkg::WB_AW-1:0]        o_wb_addr,
  output npu_buf_pkg::wb_word_t                o_wb_wdata,
  output logic [npu_buf_pkg::WB_W/8-1:0]       o_wb_be,
  // INSTB request
  output logic                                 o_instb_cs,
  output logic                                 o_instb_we,
  output logic [npu_buf_pkg::INSTB_AW-1:0]     o_instb_addr,
  output npu_buf_pkg::instb_word_t             o_instb_wdata,
  output logic [npu_buf_pkg::INSTB_W/8-1:0]    o_instb_be,
  // Read data from the banks
  input  npu_buf_pkg::iob_word_t               i_iob_rdata,
  input  npu_buf_pkg::wb_word_t                i_wb_rdata,
  input  npu_buf_pkg::instb_word_t             i_instb_rdata,
  output logic [npu_buf_pkg::BEAT_W-1:0]       o_dma_rdata,
  output logic                                 o_dma_rvalid
);
  import npu_buf_pkg::*;

  logic [1:0]         bank;
  logic [BEAT_AW-1:0] beat_addr;
  logic [1:0]         lane;
  logic               access;
  logic [1:0]         rd_bank;
  logic [1:0]         rd_lane;

  assign bank      = i_dma_addr[DMA_AW-1 -: 2];
  assign beat_addr = i_dma_addr[BEAT_AW-1:0];
  assign access    = i_dma_write | i_dma_read;

  // Lane inside the addressed word
  always_comb begin
    case (bank)
      BANK_IOB: lane = beat_addr[1:0] & 2'(IOB_BEATS - 1);
      BANK_WB:  lane = beat_addr[1:0] & 2'(WB_BEATS - 1);
      default:  lane = 2'd0;  // INSTB is one beat wide
    endcase
  end

  assign o_iob_cs   = access && (bank == BANK_IOB);
  assign o_iob_we   = i_dma_write && (bank == BANK_IOB);
  assign o_iob_addr = beat_addr[IOB_LB +: IOB_AW];
  assign o_iob_wdata = {IOB_BEATS{i_dma_wdata}};  // Replicated over lanes
  assign o_iob_be   = {{(IOB_W/8 - BEAT_BYTES){1'b0}}, i_dma_wstrb} << (BEAT_BYTES * lane);

  assign o_wb_cs    = access && (bank == BANK_WB);
  assign o_wb_we    = i_dma_write && (bank == BANK_WB);
  assign o_wb_addr  = beat_addr[WB_LB +: WB_AW];
  assign o_wb_wdata = {WB_BEATS{i_dma_wdata}};
  assign o_wb_be    = {{(WB_W/8 - BEAT_BYTES){1'b0}}, i_dma_wstrb} << (BEAT_BYTES * lane);

  // Single lane, so strobes pass straight through
  assign o_instb_cs    = access && (bank == BANK_INSTB);
  assign o_instb_we    = i_dma_write && (bank == BANK_INSTB);
  assign o_instb_addr  = beat_addr[INSTB_LB +: INSTB_AW];
  assign o_instb_wdata = {INSTB_BEATS{i_dma_wdata}};
  assign o_instb_be    = i_dma_wstrb;

  // Bank code 3 never returns data
  always_ff @(posedge xclk or negedge i_arst_n) begin
    if (!i_arst_n)
      o_dma_rvalid <= 1'b0;
    else
      o_dma_rvalid <= i_dma_read && (bank != 2'd3);
  end

  always_ff @(posedge xclk) begin
    if (i_dma_read) begin
      rd_bank <= bank;
      rd_lane <= lane;
    end
  end

  // Beat select one cycle after the request
  always_comb begin
    case (rd_bank)
      BANK_IOB:   o_dma_rdata = i_iob_rdata[BEAT_W*rd_lane[0] +: BEAT_W];
      BANK_WB:    o_dma_rdata = i_wb_rdata[BEAT_W*rd_lane +: BEAT_W];
      BANK_INSTB: o_dma_rdata = i_instb_rdata;
      default:    o_dma_rdata = '0;
    endcase
  end

  a_no_rd_wr: assert property (
    @(posedge xclk) disable iff (!i_arst_n) !(i_dma_read && i_dma_write)
  ) else $error("DMA read and write in the same cycle");

endmodule

// ==== verilog/apb_cfg_regs.sv ====
// APB control and status registers
`timescale 1ns/1ps

module apb_cfg_regs (
  input  logic                          xclk,
  input  logic                          i_arst_n,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [npu_buf_pkg::APB_AW-1:0] i_paddr,
  input  logic [31:0]                   i_pwdata,
  output logic [31:0]                   o_prdata,
  input  logic                          i_npu_done,
  output logic                          o_npu_start,
  output logic                          o_npu_stop,
  output logic                          o_dma_own,
  output logic                          o_interrupt
);
  import npu_buf_pkg::*;

  logic wr_en;
  logic ctrl_wr;
  logic irq_wr;
  logic start_req;
  logic stop_req;
  logic busy;

  assign wr_en   = i_psel & i_penable & i_pwrite;  // Access phase write
  assign ctrl_wr = wr_en && (i_paddr == REG_CTRL);
  assign irq_wr  = wr_en && (i_paddr == REG_IRQ);

  assign start_req = ctrl_wr & i_pwdata[0];
  assign stop_req  = ctrl_wr & i_pwdata[1];

  always_ff @(posedge xclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_npu_start <= 1'b0;
      o_npu_stop  <= 1'b0;
      o_dma_own   <= 1'b0;
      busy        <= 1'b0;
      o_interrupt <= 1'b0;
    end else begin
      o_npu_start <= start_req;  // One cycle pulses
      o_npu_stop  <= stop_req;

      if (ctrl_wr)
        o_dma_own <= i_pwdata[2];

      // Start has priority over done
      if (start_req)
        busy <= 1'b1;
      else if (stop_req || i_npu_done)
        busy <= 1'b0;

      // A done in the clearing cycle is kept
      if (i_npu_done)
        o_interrupt <= 1'b1;
      else if (irq_wr && i_pwdata[0])
        o_interrupt <= 1'b0;
    end
  end

  // Read data during setup and access
  always_comb begin
    o_prdata = 32'h0;
    if (i_psel && !i_pwrite) begin
      case (i_paddr)
        REG_CTRL:   o_prdata = {29'h0, o_dma_own, 2'b00};
        REG_STATUS: o_prdata = {30'h0, o_dma_own, busy};
        REG_IRQ:    o_prdata = {31'h0, o_interrupt};
        default:    o_prdata = 32'h0;
      endcase
    end
  end

  a_start_stop_excl: assert property (
    @(posedge xclk) disable iff (!i_arst_n) !(o_npu_start && o_npu_stop)
  ) else $error("npu start and stop pulsed together");

endmodule

// ==== verilog/npu_buf_pkg.sv ====
// NPU buffer system definitions
package npu_buf_pkg;

  // DMA side
  localparam int BEAT_W     = 128;
  localparam int BEAT_BYTES = BEAT_W / 8;
  localparam int DMA_AW     = 16;
  localparam int BEAT_AW    = DMA_AW - 2;  // Below the bank code

  // Bank codes, 2'd3 unused
  localparam logic [1:0] BANK_IOB   = 2'd0;
  localparam logic [1:0] BANK_WB    = 2'd1;
  localparam logic [1:0] BANK_INSTB = 2'd2;

  // Word widths
  localparam int IOB_W   = 256;
  localparam int WB_W    = 512;
  localparam int INSTB_W = 128;

  // Beats per word and lane bits in the beat address
  localparam int IOB_BEATS   = IOB_W / BEAT_W;
  localparam int WB_BEATS    = WB_W / BEAT_W;
  localparam int INSTB_BEATS = INSTB_W / BEAT_W;
  localparam int IOB_LB      = $clog2(IOB_BEATS);
  localparam int WB_LB       = $clog2(WB_BEATS);
  localparam int INSTB_LB    = $clog2(INSTB_BEATS);

  // Word address widths
  localparam int IOB_AW   = 8;
  localparam int WB_AW    = 6;
  localparam int INSTB_AW = 8;

  typedef logic [IOB_W-1:0]   iob_word_t;
  typedef logic [WB_W-1:0]    wb_word_t;
  typedef logic [INSTB_W-1:0] instb_word_t;

  // APB register map
  localparam int APB_AW = 8;
  localparam logic [APB_AW-1:0] REG_CTRL   = 8'h00;
  localparam logic [APB_AW-1:0] REG_STATUS = 8'h04;
  localparam logic [APB_AW-1:0] REG_IRQ    = 8'h08;

endpackage
